// File: source/rob_pkg.sv
// ---------------------------------------------------------------------------
// Sizes, operation ID and bundle types shared by the reorder buffer RTL and
// its testbench. Modules pull these in with a wildcard import in the body.
// ---------------------------------------------------------------------------
package rob_pkg;

    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;
    localparam int DEC_W     = 2;
    localparam int EXE_W     = 2;
    localparam int COM_W     = 2;
    localparam int XLEN      = 32;
    localparam int CAUSE_W   = 5;
    localparam int LREG_W    = 5;                              // logical register index
    localparam int CNT_W     = ROB_IDX_W + 1;                  // holds 0..ROB_DEPTH
    localparam int COM_NUM_W = $clog2(COM_W + 1);              // holds 0..COM_W
    localparam int WR_PORTS  = (DEC_W > EXE_W) ? DEC_W : EXE_W; // entry store write lanes

    // a lane is live when valid is set, idx names the ROB entry
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] idx;
    } op_id_t;

    typedef union packed {
        logic [XLEN-1:0] tval;   // faulting address or bad instruction
        logic [XLEN-1:0] target; // resolved branch target
    } exe_info_u;

    typedef struct packed {
        op_id_t            op_id;
        logic [XLEN-1:0]   pc;
        logic [2:0]        delta;  // instruction length in bytes
        logic [LREG_W-1:0] lrd;
    } dec_bundle_t;

    typedef struct packed {
        op_id_t             op_id;
        logic               exc;
        logic [CAUSE_W-1:0] cause;
        logic               mispredict;
        exe_info_u          info;
    } exe_bundle_t;

    typedef struct packed {
        op_id_t            op_id;
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] lrd;
    } rob_dec_t;

    typedef struct packed {
        logic               exc;
        logic [CAUSE_W-1:0] cause;
        exe_info_u          info;
    } rob_exe_t;

    typedef struct packed {
        op_id_t            op_id;
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] lrd;
    } com_bundle_t;

    typedef struct packed {
        logic            valid;
        op_id_t          op_id;  // entries younger than this one are dropped
        logic [XLEN-1:0] npc;
    } red_bundle_t;

endpackage

// File: source/rob_entry_ram.sv
// ---------------------------------------------------------------------------
// ROB entry store with one write port per lane and COM_W asynchronous reads
// at the head. The element type picks decode or execution fields.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rob_entry_ram #(
    parameter type entry_t = rob_pkg::rob_dec_t
) (
    input  logic                                                clk,
    input  logic [rob_pkg::WR_PORTS-1:0][rob_pkg::ROB_IDX_W-1:0] waddr,
    input  entry_t [rob_pkg::WR_PORTS-1:0]                      wdata,
    input  logic [rob_pkg::WR_PORTS-1:0]                        wena,
    input  logic [rob_pkg::COM_W-1:0][rob_pkg::ROB_IDX_W-1:0]    raddr,
    output entry_t [rob_pkg::COM_W-1:0]                         rdata
);
    import rob_pkg::*;

    entry_t mem [ROB_DEPTH];

    // lanes are applied in order, so a higher lane wins on the same index
    always_ff @(posedge clk) begin
        for (int i = 0; i < WR_PORTS; i++) begin
            if (wena[i]) begin
                mem[waddr[i]] <= wdata[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            rdata[i] = mem[raddr[i]]; // head entries, no read latency
        end
    end

endmodule

// File: source/rob_status.sv
// ---------------------------------------------------------------------------
// ROB bookkeeping: head pointer, live entry count and executed bits.
// Counts new allocations, retires committed entries and truncates on redirect.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rob_status (
    input  logic                                        clk,
    input  logic                                        rst,
    input  rob_pkg::dec_bundle_t [rob_pkg::DEC_W-1:0]   dec,
    input  rob_pkg::exe_bundle_t [rob_pkg::EXE_W-1:0]   exe,
    input  logic [rob_pkg::COM_NUM_W-1:0]               com_num,
    input  rob_pkg::red_bundle_t                        redirect,
    output logic [rob_pkg::ROB_IDX_W-1:0]               front,
    output logic [rob_pkg::CNT_W-1:0]                   count,
    output logic [rob_pkg::COM_W-1:0]                   head_ready,
    output logic [rob_pkg::ROB_IDX_W-1:0]               alloc_id,
    output logic [rob_pkg::CNT_W-1:0]                   free_slots
);
    import rob_pkg::*;

    logic [CNT_W-1:0]     count_q;   // entries held before this cycle's redirect
    logic [CNT_W-1:0]     kept;      // entries at or before the redirect id
    logic [CNT_W-1:0]     alloc_num;
    logic [ROB_DEPTH-1:0] executed;

    always_comb begin
        kept = {1'b0, ROB_IDX_W'(redirect.op_id.idx - front)} + CNT_W'(1);
        // a trap redirect names the entry that already left, so nothing stays
        if (kept > count_q) begin
            kept = '0;
        end
    end

    always_comb count = redirect.valid ? kept : count_q;

    // only lanes beyond the live window add entries
    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < DEC_W; i++) begin
            if (dec[i].op_id.valid && {1'b0, ROB_IDX_W'(dec[i].op_id.idx - front)} >= count) begin
                alloc_num = alloc_num + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            front   <= '0;
            count_q <= '0;
        end else begin
            front   <= front + ROB_IDX_W'(com_num);
            count_q <= count + alloc_num - CNT_W'(com_num);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            executed <= '0;
        end else begin
            for (int i = 0; i < DEC_W; i++) begin
                if (dec[i].op_id.valid) begin
                    executed[dec[i].op_id.idx] <= 1'b0; // fresh entry waits for its result
                end
            end
            for (int i = 0; i < EXE_W; i++) begin
                if (exe[i].op_id.valid) begin
                    executed[exe[i].op_id.idx] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            head_ready[i] = executed[front + ROB_IDX_W'(i)];
        end
    end

    always_comb alloc_id   = front + ROB_IDX_W'(count);
    always_comb free_slots = CNT_W'(ROB_DEPTH) - count;

endmodule

// File: source/mispredict_pick.sv
// ---------------------------------------------------------------------------
// Picks the oldest mispredicted execution result of the cycle, age taken
// from the ROB head, and holds it for exactly one cycle.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module mispredict_pick (
    input  logic                                      clk,
    input  logic                                      rst,
    input  rob_pkg::exe_bundle_t [rob_pkg::EXE_W-1:0] exe,
    input  logic [rob_pkg::ROB_IDX_W-1:0]             front,
    output rob_pkg::exe_bundle_t                      mis_reg
);
    import rob_pkg::*;

    exe_bundle_t mis_first;

    // distance from the head decides age across the index wrap
    function automatic logic older(input logic [ROB_IDX_W-1:0] a,
                                   input logic [ROB_IDX_W-1:0] b,
                                   input logic [ROB_IDX_W-1:0] base);
        return ROB_IDX_W'(a - base) < ROB_IDX_W'(b - base);
    endfunction

    always_comb begin
        mis_first = '0;
        for (int i = 0; i < EXE_W; i++) begin
            if (exe[i].op_id.valid && exe[i].mispredict) begin
                if (!mis_first.op_id.valid ||
                    older(exe[i].op_id.idx, mis_first.op_id.idx, front)) begin
                    mis_first = exe[i];
                end
            end
        end
    end

    // empty pick in the next cycle drops it again
    always_ff @(posedge clk) begin
        if (rst) begin
            mis_reg <= '0;
        end else begin
            mis_reg <= mis_first;
        end
    end

endmodule

// File: source/commit_select.sv
// ---------------------------------------------------------------------------
// In-order commit of up to COM_W ready head entries per cycle. Keeps a copy
// of the youngest committed entry so a trap can be raised one cycle later.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module commit_select (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [rob_pkg::COM_W-1:0]                 head_ready,
    input  logic [rob_pkg::CNT_W-1:0]                 count,
    input  rob_pkg::rob_dec_t [rob_pkg::COM_W-1:0]    dec_rd,
    input  rob_pkg::rob_exe_t [rob_pkg::COM_W-1:0]    exe_rd,
    input  logic                                      exc_pending,
    output rob_pkg::com_bundle_t [rob_pkg::COM_W-1:0] com,
    output logic [rob_pkg::COM_NUM_W-1:0]             com_num,
    output rob_pkg::rob_dec_t                         last_dec,
    output rob_pkg::rob_exe_t                         last_exe
);
    import rob_pkg::*;

    logic [COM_W-1:0]     take;
    logic                 go;        // all earlier lanes commit and none traps
    logic [COM_NUM_W-1:0] youngest;  // lane of the last committed entry

    always_comb begin
        go       = !exc_pending;     // trap cycle blocks every lane
        take     = '0;
        youngest = '0;
        com_num  = '0;
        for (int i = 0; i < COM_W; i++) begin
            take[i] = go && (CNT_W'(i) < count) && head_ready[i];
            go      = take[i] && !exe_rd[i].exc; // a faulting entry closes the group
            if (take[i]) begin
                youngest = COM_NUM_W'(i);
                com_num  = com_num + COM_NUM_W'(1);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            com[i] = '0;
            if (take[i]) begin
                com[i].op_id.valid = 1'b1;
                com[i].op_id.idx   = dec_rd[i].op_id.idx;
                com[i].pc          = dec_rd[i].pc;
                com[i].lrd         = dec_rd[i].lrd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (com_num != '0) begin
            last_dec <= dec_rd[youngest];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_exe <= '0;
        end else if (com_num != '0) begin
            last_exe <= exe_rd[youngest];
        end else if (last_exe.exc) begin
            last_exe.exc <= 1'b0;    // trap was shown this cycle
        end
    end

endmodule

// File: source/redirect_gen.sv
// ---------------------------------------------------------------------------
// Builds the trap outputs and the fetch redirect. A trap from the last
// committed entry takes the cycle, otherwise the registered mispredict does.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module redirect_gen (
    input  rob_pkg::rob_dec_t             last_dec,
    input  rob_pkg::rob_exe_t             last_exe,
    input  rob_pkg::exe_bundle_t          mis_reg,
    input  logic [rob_pkg::XLEN-1:0]      trap_vec,
    output logic                          exception,
    output logic [rob_pkg::XLEN-1:0]      epc,
    output logic [rob_pkg::CAUSE_W-1:0]   cause,
    output logic [rob_pkg::XLEN-1:0]      tval,
    output rob_pkg::red_bundle_t          redirect,
    output logic                          exc_pending
);
    import rob_pkg::*;

    // holds commit off while the trap is shown
    always_comb exc_pending = last_exe.exc;

    always_comb begin
        exception = 1'b0;
        epc       = '0;
        cause     = '0;
        tval      = '0;
        redirect  = '0;
        if (last_exe.exc) begin
            exception      = 1'b1;
            epc            = last_dec.pc;
            cause          = last_exe.cause;
            tval           = last_exe.info.tval;
            redirect.valid = 1'b1;
            redirect.op_id = last_dec.op_id; // already retired, so everything flushes
            redirect.npc   = trap_vec;
        end else if (mis_reg.op_id.valid) begin
            redirect.valid = 1'b1;
            redirect.op_id = mis_reg.op_id;
            redirect.npc   = mis_reg.info.target & ~XLEN'(1); // keep fetch halfword aligned
        end
    end

endmodule

// File: source/rob_commit_top.sv
// ---------------------------------------------------------------------------
// Reorder buffer with in-order commit. Decode lanes allocate entries,
// execution lanes complete them, commit lanes retire them in order.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rob_commit_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  rob_pkg::dec_bundle_t [rob_pkg::DEC_W-1:0] dec,
    input  rob_pkg::exe_bundle_t [rob_pkg::EXE_W-1:0] exe,
    input  logic [rob_pkg::XLEN-1:0]                  trap_vec,
    output rob_pkg::com_bundle_t [rob_pkg::COM_W-1:0] com,
    output logic                                      exception,
    output logic [rob_pkg::XLEN-1:0]                  epc,
    output logic [rob_pkg::CAUSE_W-1:0]               cause,
    output logic [rob_pkg::XLEN-1:0]                  tval,
    output rob_pkg::red_bundle_t                      redirect,
    output logic [rob_pkg::ROB_IDX_W-1:0]             alloc_id,
    output logic [rob_pkg::CNT_W-1:0]                 free_slots
);
    import rob_pkg::*;

    logic [ROB_IDX_W-1:0]               front;
    logic [CNT_W-1:0]                   count;
    logic [COM_W-1:0]                   head_ready;
    logic [COM_NUM_W-1:0]               com_num;
    logic                               exc_pending;
    logic [COM_W-1:0][ROB_IDX_W-1:0]    head_idx;
    logic [WR_PORTS-1:0][ROB_IDX_W-1:0] dec_waddr;
    logic [WR_PORTS-1:0][ROB_IDX_W-1:0] exe_waddr;
    logic [WR_PORTS-1:0]                dec_wena;
    logic [WR_PORTS-1:0]                exe_wena;
    rob_dec_t [WR_PORTS-1:0]            dec_wdata;
    rob_exe_t [WR_PORTS-1:0]            exe_wdata;
    rob_dec_t [COM_W-1:0]               dec_rd;
    rob_exe_t [COM_W-1:0]               exe_rd;
    rob_dec_t                           last_dec;
    rob_exe_t                           last_exe;
    exe_bundle_t                        mis_reg;

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            head_idx[i] = front + ROB_IDX_W'(i);
        end
    end

    // unused write lanes stay disabled
    always_comb begin
        dec_waddr = '0;
        dec_wdata = '0;
        dec_wena  = '0;
        for (int i = 0; i < DEC_W; i++) begin
            dec_waddr[i]       = dec[i].op_id.idx;
            dec_wena[i]        = dec[i].op_id.valid;
            dec_wdata[i].op_id = dec[i].op_id;
            dec_wdata[i].pc    = dec[i].pc;
            dec_wdata[i].lrd   = dec[i].lrd;
        end
    end

    always_comb begin
        exe_waddr = '0;
        exe_wdata = '0;
        exe_wena  = '0;
        for (int i = 0; i < EXE_W; i++) begin
            exe_waddr[i]       = exe[i].op_id.idx;
            exe_wena[i]        = exe[i].op_id.valid;
            exe_wdata[i].exc   = exe[i].exc;
            exe_wdata[i].cause = exe[i].cause;
            exe_wdata[i].info  = exe[i].info;
        end
    end

    rob_entry_ram #(.entry_t(rob_dec_t)) u_dec_ram (
        .clk(clk), .waddr(dec_waddr), .wdata(dec_wdata), .wena(dec_wena),
        .raddr(head_idx), .rdata(dec_rd)
    );

    rob_entry_ram #(.entry_t(rob_exe_t)) u_exe_ram (
        .clk(clk), .waddr(exe_waddr), .wdata(exe_wdata), .wena(exe_wena),
        .raddr(head_idx), .rdata(exe_rd)
    );

    rob_status u_status (
        .clk(clk), .rst(rst), .dec(dec), .exe(exe), .com_num(com_num),
        .redirect(redirect), .front(front), .count(count), .head_ready(head_ready),
        .alloc_id(alloc_id), .free_slots(free_slots)
    );

    mispredict_pick u_mis_pick (
        .clk(clk), .rst(rst), .exe(exe), .front(front), .mis_reg(mis_reg)
    );

    commit_select u_commit (
        .clk(clk), .rst(rst), .head_ready(head_ready), .count(count),
        .dec_rd(dec_rd), .exe_rd(exe_rd), .exc_pending(exc_pending),
        .com(com), .com_num(com_num), .last_dec(last_dec), .last_exe(last_exe)
    );

    redirect_gen u_redirect (
        .last_dec(last_dec), .last_exe(last_exe), .mis_reg(mis_reg), .trap_vec(trap_vec),
        .exception(exception), .epc(epc), .cause(cause), .tval(tval),
        .redirect(redirect), .exc_pending(exc_pending)
    );

endmodule

// File: sim/rob_commit_checker.sv
// ---------------------------------------------------------------------------
// Concurrent assertions on the reorder buffer top level, attached with bind.
// Covers the entry count bound, the trap pulse and the commit lane pattern.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rob_commit_checker (
    input logic                                      clk,
    input logic                                      rst,
    input logic [rob_pkg::CNT_W-1:0]                 count,
    input logic                                      exception,
    input rob_pkg::red_bundle_t                      redirect,
    input rob_pkg::com_bundle_t [rob_pkg::COM_W-1:0] com
);
    import rob_pkg::*;

    logic [COM_W-1:0] lanes;  // valid bit per commit lane
    int               fail_count;

    initial fail_count = 0;

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            lanes[i] = com[i].op_id.valid;
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(ROB_DEPTH))
        else begin
            $error("entry count above ROB depth");
            fail_count++;
        end

    // trap is shown for one cycle only
    trap_single_cycle: assert property (@(posedge clk) disable iff (rst)
        exception |=> !exception)
        else begin
            $error("exception held for more than one cycle");
            fail_count++;
        end

    // valid lanes form a run starting at lane 0
    lanes_contiguous: assert property (@(posedge clk) disable iff (rst)
        (lanes & (lanes + COM_W'(1))) == '0)
        else begin
            $error("commit lanes not contiguous");
            fail_count++;
        end

    no_commit_on_trap: assert property (@(posedge clk) disable iff (rst)
        exception |-> lanes == '0)
        else begin
            $error("commit during exception cycle");
            fail_count++;
        end

endmodule

bind rob_commit_top rob_commit_checker u_checker (.*);

// File: sim/tb_rob_commit.sv
// ---------------------------------------------------------------------------
// Directed testbench for the reorder buffer: allocation, out-of-order
// execution, exceptions, mispredicts and index wrap. Commits are scoreboarded.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_rob_commit;
    import rob_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 150;   // generous bound per test
    localparam int DRAIN_LIMIT     = 100;

    logic                     clk;
    logic                     rst;
    dec_bundle_t [DEC_W-1:0]  dec;
    exe_bundle_t [EXE_W-1:0]  exe;
    logic [XLEN-1:0]          trap_vec;
    com_bundle_t [COM_W-1:0]  com;
    logic                     exception;
    logic [XLEN-1:0]          epc;
    logic [CAUSE_W-1:0]       cause;
    logic [XLEN-1:0]          tval;
    red_bundle_t              redirect;
    logic [ROB_IDX_W-1:0]     alloc_id;
    logic [CNT_W-1:0]         free_slots;

    int                   errors;
    int                   checks;
    int                   seed;
    int                   exc_seen;
    int                   red_seen;
    logic [ROB_IDX_W-1:0] next_idx;     // next entry to allocate after flushes
    logic [ROB_IDX_W-1:0] exp_idx[$];   // scoreboard, allocation order
    logic [XLEN-1:0]      exp_pc[$];
    logic [LREG_W-1:0]    exp_lrd[$];
    logic [XLEN-1:0]      next_pc;
    logic [ROB_DEPTH-1:0] done;         // result already driven
    logic [XLEN-1:0]      seen_epc;
    logic [XLEN-1:0]      seen_tval;
    logic [XLEN-1:0]      seen_npc;
    logic [CAUSE_W-1:0]   seen_cause;
    logic [ROB_IDX_W-1:0] seen_red_idx;

    rob_commit_top u_rob_commit_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string what, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compares this cycle's commit lanes and records trap or redirect
    task automatic collect();
        for (int i = 0; i < COM_W; i++) begin
            if (com[i].op_id.valid) begin
                if (exp_idx.size() == 0) begin
                    errors++;
                    $display("Entry %0d committed but none was expected", com[i].op_id.idx);
                end else begin
                    check("commit id", XLEN'(com[i].op_id.idx), XLEN'(exp_idx.pop_front()));
                    check("commit pc", com[i].pc, exp_pc.pop_front());
                    check("commit lrd", XLEN'(com[i].lrd), XLEN'(exp_lrd.pop_front()));
                end
                if (!done[com[i].op_id.idx]) begin
                    errors++;
                    $display("Entry %0d committed before its execution", com[i].op_id.idx);
                end
            end
        end
        if (exception) begin
            exc_seen++;
            seen_epc   = epc;
            seen_cause = cause;
            seen_tval  = tval;
            seen_npc   = redirect.npc;
        end else if (redirect.valid) begin
            red_seen++;
            seen_npc     = redirect.npc;
            seen_red_idx = redirect.op_id.idx;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        @(negedge clk);
        dec = '0;
        exe = '0;
        collect();
    endtask

    // allocates n ops, the first n_commit of them are expected to commit
    task automatic alloc_ops(input int n, input int n_commit,
                             output logic [ROB_IDX_W-1:0] base);
        logic [ROB_IDX_W-1:0] idx;
        check("alloc id", XLEN'(alloc_id), XLEN'(next_idx));
        base = next_idx;
        for (int k = 0; k < n; k += DEC_W) begin
            for (int l = 0; l < DEC_W; l++) begin
                if (k + l < n) begin
                    idx = base + ROB_IDX_W'(k + l);
                    dec[l].op_id.valid = 1'b1;
                    dec[l].op_id.idx   = idx;
                    dec[l].pc          = next_pc;
                    dec[l].delta       = 3'd4;
                    dec[l].lrd         = LREG_W'(k + l + 1);
                    done[idx]          = 1'b0;
                    if (k + l < n_commit) begin
                        exp_idx.push_back(idx);
                        exp_pc.push_back(next_pc);
                        exp_lrd.push_back(LREG_W'(k + l + 1));
                    end
                    next_pc = next_pc + 32'd4;
                end
            end
            tick();
        end
        next_idx = base + ROB_IDX_W'(n_commit); // younger ops get flushed
    endtask

    task automatic set_exe(input int lane, input logic [ROB_IDX_W-1:0] idx, input logic exc,
                           input logic mis, input logic [XLEN-1:0] info);
        exe[lane].op_id.valid = 1'b1;
        exe[lane].op_id.idx   = idx;
        exe[lane].exc         = exc;
        exe[lane].cause       = exc ? CAUSE_W'(13) : '0;
        exe[lane].mispredict  = mis;
        exe[lane].info        = info;
        done[idx]             = 1'b1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (free_slots != CNT_W'(ROB_DEPTH) && n < DRAIN_LIMIT) begin
            tick();
            n++;
        end
        if (n == DRAIN_LIMIT) begin
            errors++;
            $display("ROB did not drain within %0d cycles", DRAIN_LIMIT);
        end
        check("commits still expected", XLEN'(exp_idx.size()), '0);
    endtask

    // allocates n ops and executes them one per cycle
    task automatic run_batch(input int n, input logic shuffle);
        logic [ROB_IDX_W-1:0] base;
        int                   order[ROB_DEPTH];
        int                   j;
        int                   t;
        alloc_ops(n, n, base);
        for (int i = 0; i < n; i++) order[i] = i;
        for (int i = n - 1; i > 0 && shuffle; i--) begin
            j        = int'($unsigned($random(seed)) % (i + 1));
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < n; i++) begin
            set_exe(0, base + ROB_IDX_W'(order[i]), 1'b0, 1'b0, '0);
            tick();
        end
        wait_drain();
    endtask

    task automatic reset_state();
        check("free slots after reset", XLEN'(free_slots), XLEN'(ROB_DEPTH));
        check("redirect after reset", XLEN'(redirect.valid), '0);
        check("exception after reset", XLEN'(exception), '0);
        for (int i = 0; i < COM_W; i++) begin
            check("commit after reset", XLEN'(com[i].op_id.valid), '0);
        end
    endtask

    task automatic exception_flush();
        logic [ROB_IDX_W-1:0] base;
        logic [XLEN-1:0]      base_pc;
        exc_seen = 0;
        base_pc  = next_pc;
        alloc_ops(6, 4, base);
        for (int p = 0; p < 3; p++) begin
            set_exe(0, base + ROB_IDX_W'(2 * p), 1'b0, 1'b0, '0);
            set_exe(1, base + ROB_IDX_W'(2 * p + 1), p == 1, 1'b0,
                    (p == 1) ? 32'hdead_beef : '0);
            tick();
        end
        wait_drain();
        check("exception pulses", XLEN'(exc_seen), 32'd1);
        check("epc", seen_epc, base_pc + 32'd12);
        check("cause", XLEN'(seen_cause), 32'd13);
        check("tval", seen_tval, 32'hdead_beef);
        check("trap npc", seen_npc, trap_vec);
    endtask

    // both set gives two mispredicts in one cycle with the younger on lane 0
    task automatic mispredict_redirect(input logic both);
        logic [ROB_IDX_W-1:0] base;
        red_seen = 0;
        exc_seen = 0;
        alloc_ops(4, 2, base);
        set_exe(0, base, 1'b0, 1'b0, '0);
        if (both) begin
            tick();
            set_exe(0, base + ROB_IDX_W'(3), 1'b0, 1'b1, 32'h0000_3000);
        end
        set_exe(1, base + ROB_IDX_W'(1), 1'b0, 1'b1, both ? 32'h0000_4000 : 32'h0000_2001);
        tick();
        wait_drain();
        check("redirects", XLEN'(red_seen), 32'd1);
        check("redirect id", XLEN'(seen_red_idx), XLEN'(base + ROB_IDX_W'(1)));
        check("redirect npc", seen_npc, both ? 32'h0000_4000 : 32'h0000_2000);
        check("exceptions", XLEN'(exc_seen), '0);
    endtask

    initial begin
        int assert_fails;
        rst      = 1'b1;
        dec      = '0;
        exe      = '0;
        trap_vec = 32'h8000_0100;
        errors   = 0;
        checks   = 0;
        seed     = 20;
        next_idx = '0;
        next_pc  = 32'h0000_1000;
        done     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state();
        run_batch(8, 1'b1);
        exception_flush();
        mispredict_redirect(1'b0);
        mispredict_redirect(1'b1);
        repeat (3) run_batch(8, 1'b0);  // crosses the index wrap
        assert_fails = u_rob_commit_top.u_checker.fail_count;
        errors       = errors + assert_fails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: files.f
source/rob_pkg.sv
source/rob_entry_ram.sv
source/rob_status.sv
source/mispredict_pick.sv
source/commit_select.sv
source/redirect_gen.sv
source/rob_commit_top.sv
sim/rob_commit_checker.sv
sim/tb_rob_commit.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --top-module tb_rob_commit \
        -f files.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
